// ==== test/user_domain_input.txt ====
# OBI access vectors, all fields hex: req we addr be wdata id exp_rdata exp_err
# A line with g starts a new back-to-back group; req 0 is an idle cycle
g
1 0 00000000 f 00000000 0 55534552 0
1 0 00000004 f 00000000 1 5f444f4d 0
1 0 00000008 f 00000000 2 5f524f4d 0
1 0 0000000c f 00000000 3 00010000 0
1 0 00000010 f 00000000 0 00001000 0
1 0 00000014 f 00000000 1 00000040 0
1 0 00000018 f 00000000 2 00000008 0
1 0 0000001c f 00000000 3 c0ffee01 0
g
1 1 00000008 f deadbeef 1 00000000 1
g
1 1 00001000 f 11223344 0 00000000 0
1 1 00001004 f aabbccdd 1 00000000 0
1 1 000010fc f 0badf00d 2 00000000 0
1 0 00001000 f 00000000 3 11223344 0
1 1 00001000 5 55667788 0 00000000 0
1 0 00001000 f 00000000 1 11663388 0
1 1 00001004 a 99ee77ff 2 00000000 0
1 0 00001004 f 00000000 3 99bb77dd 0
1 1 000010fc 8 fe000000 0 00000000 0
1 0 000010fc f 00000000 1 feadf00d 0
g
1 0 00000800 f 00000000 2 00000000 1
1 1 00002000 f 12345678 3 00000000 1
1 0 00000020 f 00000000 0 00000000 1
g
1 0 00000004 f 00000000 1 5f444f4d 0
1 0 00001004 f 00000000 2 99bb77dd 0
1 0 00000800 f 00000000 3 00000000 1
1 1 00001008 f 0000cafe 0 00000000 0
1 0 00001008 f 00000000 1 0000cafe 0
1 1 0000001c f 12345678 2 00000000 1
0 0 00000000 0 00000000 0 00000000 0
1 0 0000001c f 00000000 3 c0ffee01 0
1 0 000010fc f 00000000 0 feadf00d 0

// ==== user_domain.f ====
+incdir+include
hw/user_pkg.sv
hw/user_rom.sv
hw/user_sram.sv
hw/user_obi_decoder.sv
hw/user_domain.sv
test/user_domain_tb.sv

// ==== Makefile ====
# Verilator build, run and lint of the user domain testbench.
# Any variable can be overridden, for example: make TOP=user_domain_tb LOG=run.log

VERILATOR ?= verilator
TOP       ?= user_domain_tb
FLIST     ?= user_domain.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The simulation status is ignored; the log search decides pass or fail
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/user_domain_tb.sv ====
// ####################################################################
// Testbench of the user domain. Replays the access vectors from the
// input file over OBI and checks every response against the file.
// ####################################################################

`timescale 1ns/1ns

module user_domain_tb;

  import user_pkg::*;

  // Cycles to wait for outstanding responses at the end
  localparam int DRAIN_LIMIT = 20;

  logic      clk_i;
  logic      rst_n_i;
  logic      obi_req_i;
  obi_addr_t obi_addr_i;
  logic      obi_we_i;
  obi_be_t   obi_be_i;
  obi_data_t obi_wdata_i;
  obi_id_t   obi_aid_i;
  logic      obi_gnt_o;
  logic      obi_rvalid_o;
  obi_data_t obi_rdata_o;
  obi_id_t   obi_rid_o;
  logic      obi_err_o;

  // Expected responses, oldest first
  obi_data_t exp_rdata_q [$];
  obi_id_t   exp_id_q [$];
  logic      exp_err_q [$];
  // Cycle in which each response is due
  int        exp_cycle_q [$];
  // Rising edges seen so far
  int        cycle_cnt;

  user_domain i_user_domain (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .obi_req_i    (obi_req_i),
    .obi_addr_i   (obi_addr_i),
    .obi_we_i     (obi_we_i),
    .obi_be_i     (obi_be_i),
    .obi_wdata_i  (obi_wdata_i),
    .obi_aid_i    (obi_aid_i),
    .obi_gnt_o    (obi_gnt_o),
    .obi_rvalid_o (obi_rvalid_o),
    .obi_rdata_o  (obi_rdata_o),
    .obi_rid_o    (obi_rid_o),
    .obi_err_o    (obi_err_o)
  );

  // 10 ns clock
  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // Stops the run with a reason in plain words
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped on a failed check");
  endtask

  task automatic check_data(input string name, input obi_data_t got, input obi_data_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic check_id(input string name, input obi_id_t got, input obi_id_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "Id mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "Flag mismatch");
    end
  endtask

  // Pops the oldest expectation and compares it with the bus
  task automatic check_response();
    obi_data_t exp_rdata;
    obi_id_t   exp_id;
    logic      exp_err;
    int        exp_cycle;
    exp_rdata = exp_rdata_q.pop_front();
    exp_id    = exp_id_q.pop_front();
    exp_err   = exp_err_q.pop_front();
    exp_cycle = exp_cycle_q.pop_front();
    if (exp_cycle != cycle_cnt) begin
      fail_run("A response did not arrive one cycle after its request");
    end else begin
      check_id("obi_rid_o", obi_rid_o, exp_id);
      check_data("obi_rdata_o", obi_rdata_o, exp_rdata);
      check_bit("obi_err_o", obi_err_o, exp_err);
    end
  endtask

  // Monitor, inputs only move on the falling edge
  always @(posedge clk_i) begin
    check_bit("obi_gnt_o", obi_gnt_o, obi_req_i);
    // State is still unknown before the first reset edge
    if (cycle_cnt != 0) begin
      if (obi_rvalid_o === 1'b1) begin
        if (exp_id_q.size() == 0) begin
          fail_run("A response came with no request outstanding");
        end else begin
          check_response();
        end
      end else begin
        check_bit("obi_rvalid_o", obi_rvalid_o, 1'b0);
        if (exp_id_q.size() != 0 && exp_cycle_q[0] <= cycle_cnt) begin
          fail_run("An expected response never arrived");
        end
      end
    end
    cycle_cnt++;
  end

  task automatic drive_idle();
    @(negedge clk_i);
    obi_req_i   = 1'b0;
    obi_we_i    = 1'b0;
    obi_addr_i  = '0;
    obi_be_i    = '0;
    obi_wdata_i = '0;
    obi_aid_i   = '0;
  endtask

  // One vector line; an accepted request queues its response
  task automatic drive_access(input logic [31:0] v_req, input logic [31:0] v_we,
                              input logic [31:0] v_addr, input logic [31:0] v_be,
                              input logic [31:0] v_wdata, input logic [31:0] v_id,
                              input logic [31:0] v_rdata, input logic [31:0] v_err);
    @(negedge clk_i);
    obi_req_i   = v_req[0];
    obi_we_i    = v_we[0];
    obi_addr_i  = obi_addr_t'(v_addr);
    obi_be_i    = obi_be_t'(v_be);
    obi_wdata_i = obi_data_t'(v_wdata);
    obi_aid_i   = obi_id_t'(v_id);
    if (v_req[0]) begin
      exp_rdata_q.push_back(obi_data_t'(v_rdata));
      exp_id_q.push_back(obi_id_t'(v_id));
      exp_err_q.push_back(v_err[0]);
      // Accepted at the next edge, answered at the one after
      exp_cycle_q.push_back(cycle_cnt + 1);
    end
  endtask

  // Reads the vector file; a g line opens a new back-to-back group
  task automatic run_vectors(input int fd);
    string       line;
    int          fields;
    int unsigned idle;
    logic [31:0] v_req, v_we, v_addr, v_be, v_wdata, v_id, v_rdata, v_err;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") begin
        if (line[0] == "g") begin
          // Random gap between groups
          idle = $urandom_range(2, 0);
          repeat (idle) drive_idle();
        end else begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h", v_req, v_we, v_addr,
                           v_be, v_wdata, v_id, v_rdata, v_err);
          if (fields != 8) begin
            fail_run("A line of the vector file could not be parsed");
          end else begin
            drive_access(v_req, v_we, v_addr, v_be, v_wdata, v_id, v_rdata, v_err);
          end
        end
      end
    end
    drive_idle();
  endtask

  // Bounded wait for the queue to empty, then a short quiet tail
  task automatic drain_responses(output bit drained);
    int waited;
    waited = 0;
    while (exp_id_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    repeat (2) @(negedge clk_i);
    drained = (exp_id_q.size() == 0);
  endtask

  initial begin
    int fd;
    bit drained;
    cycle_cnt   = 0;
    rst_n_i     = 1'b0;
    obi_req_i   = 1'b0;
    obi_we_i    = 1'b0;
    obi_addr_i  = '0;
    obi_be_i    = '0;
    obi_wdata_i = '0;
    obi_aid_i   = '0;
    void'($urandom(82));
    // Reset held over three rising edges
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    fd = $fopen("test/user_domain_input.txt", "r");
    if (fd == 0) begin
      fail_run("The vector file test/user_domain_input.txt could not be opened");
    end else begin
      run_vectors(fd);
      $fclose(fd);
      drain_responses(drained);
      if (drained) begin
        $display("Finished with no errors");
        $finish;
      end else begin
        fail_run("Timed out waiting for outstanding responses");
      end
    end
  end

endmodule

// ==== hw/user_domain.sv ====
// ####################################################################
// Top level of the user domain. One OBI subordinate port feeding
// the decoder, which serves the ID ROM and the scratch SRAM.
// ####################################################################

`timescale 1ns/1ns

module user_domain (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // OBI request
  input  logic                obi_req_i,
  input  user_pkg::obi_addr_t obi_addr_i,
  input  logic                obi_we_i,
  input  user_pkg::obi_be_t   obi_be_i,
  input  user_pkg::obi_data_t obi_wdata_i,
  input  user_pkg::obi_id_t   obi_aid_i,
  // OBI response
  output logic                obi_gnt_o,
  output logic                obi_rvalid_o,
  output user_pkg::obi_data_t obi_rdata_o,
  output user_pkg::obi_id_t   obi_rid_o,
  output logic                obi_err_o
);

  import user_pkg::*;

  // Strobes from the decoder
  logic      rom_req;
  logic      sram_req;
  // Memory responses back to the decoder
  obi_data_t rom_rdata;
  obi_data_t sram_rdata;
  logic      rom_err;
  logic      sram_err;

  user_obi_decoder i_user_obi_decoder (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .obi_req_i    (obi_req_i),
    .obi_we_i     (obi_we_i),
    .obi_addr_i   (obi_addr_i),
    .obi_aid_i    (obi_aid_i),
    .obi_gnt_o    (obi_gnt_o),
    .obi_rvalid_o (obi_rvalid_o),
    .obi_err_o    (obi_err_o),
    .obi_rdata_o  (obi_rdata_o),
    .obi_rid_o    (obi_rid_o),
    .rom_req_o    (rom_req),
    .sram_req_o   (sram_req),
    .rom_rdata_i  (rom_rdata),
    .sram_rdata_i (sram_rdata),
    .rom_err_i    (rom_err),
    .sram_err_i   (sram_err)
  );

  // Address and write flag are shared by both memories
  user_rom i_user_rom (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (rom_req),
    .we_i    (obi_we_i),
    .addr_i  (obi_addr_i),
    .rdata_o (rom_rdata),
    .err_o   (rom_err)
  );

  user_sram i_user_sram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (sram_req),
    .we_i    (obi_we_i),
    .addr_i  (obi_addr_i),
    .be_i    (obi_be_i),
    .wdata_i (obi_wdata_i),
    .rdata_o (sram_rdata),
    .err_o   (sram_err)
  );

endmodule

// ==== hw/user_obi_decoder.sv ====
// ####################################################################
// OBI address decoder of the user domain. Raises one memory strobe
// per request and muxes the one-cycle-late response back to the bus.
// ####################################################################

`timescale 1ns/1ns

`include "user_domain_config.svh"

module user_obi_decoder (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // OBI request side
  input  logic                obi_req_i,
  input  logic                obi_we_i,
  input  user_pkg::obi_addr_t obi_addr_i,
  input  user_pkg::obi_id_t   obi_aid_i,
  // OBI response side
  output logic                obi_gnt_o,
  output logic                obi_rvalid_o,
  output logic                obi_err_o,
  output user_pkg::obi_data_t obi_rdata_o,
  output user_pkg::obi_id_t   obi_rid_o,
  // Memory strobes
  output logic                rom_req_o,
  output logic                sram_req_o,
  // Memory responses, valid one cycle after the strobe
  input  user_pkg::obi_data_t rom_rdata_i,
  input  user_pkg::obi_data_t sram_rdata_i,
  input  logic                rom_err_i,
  input  logic                sram_err_i
);

  import user_pkg::*;

  // Offsets from each region base
  obi_addr_t rom_offset;
  obi_addr_t sram_offset;
  logic      rom_hit;
  logic      sram_hit;

  // Response state of the access in flight
  logic      valid_q;
  logic      rom_sel_q;
  logic      sram_sel_q;
  logic      unmapped_q;
  obi_id_t   rid_q;

  // Both targets are always ready
  assign obi_gnt_o = obi_req_i;

  // Unsigned offset check wraps below the base
  assign rom_offset  = obi_addr_i - obi_addr_t'(`USER_DOMAIN_ROM_BASE);
  assign sram_offset = obi_addr_i - obi_addr_t'(`USER_DOMAIN_SRAM_BASE);
  assign rom_hit  = rom_offset < obi_addr_t'(`USER_DOMAIN_ROM_WORDS * 4);
  assign sram_hit = sram_offset < obi_addr_t'(`USER_DOMAIN_SRAM_WORDS * 4);

  // At most one strobe and none for a hole in the map
  assign rom_req_o  = obi_req_i & rom_hit;
  assign sram_req_o = obi_req_i & sram_hit;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q    <= 1'b0;
      rom_sel_q  <= 1'b0;
      sram_sel_q <= 1'b0;
      unmapped_q <= 1'b0;
      rid_q      <= '0;
    end else begin
      valid_q    <= obi_req_i;
      rom_sel_q  <= rom_req_o;
      sram_sel_q <= sram_req_o;
      unmapped_q <= obi_req_i & ~rom_hit & ~sram_hit;
      // Id only moves with an accepted request
      if (obi_req_i) begin
        rid_q <= obi_aid_i;
      end
    end
  end

  // Response mux one cycle after the request
  always_comb begin
    obi_rdata_o = '0;
    obi_err_o   = 1'b0;
    if (rom_sel_q) begin
      obi_rdata_o = rom_rdata_i;
      obi_err_o   = rom_err_i;
    end else if (sram_sel_q) begin
      obi_rdata_o = sram_rdata_i;
      obi_err_o   = sram_err_i;
    end else if (unmapped_q) begin
      obi_err_o = 1'b1;
    end
  end

  assign obi_rvalid_o = valid_q;
  assign obi_rid_o    = rid_q;

endmodule

// ==== hw/user_sram.sv ====
// ####################################################################
// Scratch SRAM of the user domain. Byte lanes are written at the
// strobe edge; read data comes back one cycle after the strobe.
// ####################################################################

`timescale 1ns/1ns

`include "user_domain_config.svh"

module user_sram (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  user_pkg::obi_addr_t addr_i,
  input  user_pkg::obi_be_t   be_i,
  input  user_pkg::obi_data_t wdata_i,
  output user_pkg::obi_data_t rdata_o,
  output logic                err_o
);

  import user_pkg::*;

  // Storage array, contents valid only after a write
  obi_data_t mem [`USER_DOMAIN_SRAM_WORDS];

  // Word index from byte address bits 7:2
  sram_idx_t idx;
  obi_data_t rdata_q;

  assign idx = addr_i[$bits(sram_idx_t)+1:2];

  // Only enabled lanes change
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int lane = 0; lane < `USER_DOMAIN_BYTES_PER_WORD; lane++) begin
        if (be_i[lane]) begin
          mem[idx][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
        end
      end
    end
  end

  // Read port
  // zero after a write or an idle cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem[idx];
    end else begin
      rdata_q <= '0;
    end
  end

  assign rdata_o = rdata_q;

  // Never fails, same response shape as the ROM
  assign err_o = 1'b0;

endmodule

// ==== hw/user_rom.sv ====
// ####################################################################
// Identification ROM, eight fixed words read one cycle after the
// strobe. Writes are refused with an error response.
// ####################################################################

`timescale 1ns/1ns

module user_rom (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  user_pkg::obi_addr_t addr_i,
  output user_pkg::obi_data_t rdata_o,
  output logic                err_o
);

  import user_pkg::*;

  logic     req_q;
  logic     we_q;
  // Word index taken from byte address bits 4:2
  rom_idx_t idx_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
      we_q  <= 1'b0;
      idx_q <= '0;
    end else begin
      req_q <= req_i;
      we_q  <= we_i;
      idx_q <= addr_i[$bits(rom_idx_t)+1:2];
    end
  end

  always_comb begin
    rdata_o = '0;
    err_o   = 1'b0;
    if (req_q && we_q) begin
      err_o = 1'b1;
    end else if (req_q) begin
      case (idx_q)
        // ASCII tag "USER_DOM_ROM"
        3'd0: rdata_o = 32'h5553_4552;
        3'd1: rdata_o = 32'h5F44_4F4D;
        3'd2: rdata_o = 32'h5F52_4F4D;
        // Version 1.0
        3'd3: rdata_o = 32'h0001_0000;
        // Map summary: SRAM base, SRAM words, ROM words
        3'd4: rdata_o = 32'h0000_1000;
        3'd5: rdata_o = 32'h0000_0040;
        3'd6: rdata_o = 32'h0000_0008;
        default: rdata_o = 32'hC0FF_EE01;
      endcase
    end
  end

endmodule

// ==== hw/user_pkg.sv ====
// ####################################################################
// Shared bus and index types for the user domain.
// Modules import it in their body and use scoped names on ports.
// ####################################################################

`include "user_domain_config.svh"

package user_pkg;

  // Byte address on the OBI bus
  typedef logic [`USER_DOMAIN_ADDR_W-1:0] obi_addr_t;

  // One bus data word
  typedef logic [`USER_DOMAIN_DATA_W-1:0] obi_data_t;

  // One enable per byte lane
  typedef logic [`USER_DOMAIN_BYTES_PER_WORD-1:0] obi_be_t;

  // Transaction id, echoed back as rid
  typedef logic [`USER_DOMAIN_ID_W-1:0] obi_id_t;

  // Word index into the identification ROM
  typedef logic [$clog2(`USER_DOMAIN_ROM_WORDS)-1:0] rom_idx_t;

  // Word index into the scratch SRAM
  typedef logic [$clog2(`USER_DOMAIN_SRAM_WORDS)-1:0] sram_idx_t;

endpackage

// ==== include/user_domain_config.svh ====
// ####################################################################
// Global widths, memory depths and region map of the user domain.
// Included by the package and by every module that needs a constant.
// ####################################################################

`ifndef USER_DOMAIN_CONFIG_SVH
`define USER_DOMAIN_CONFIG_SVH

// OBI bus widths
`define USER_DOMAIN_ADDR_W 32
`define USER_DOMAIN_DATA_W 32
// Transaction id width, up to four ids in flight
`define USER_DOMAIN_ID_W 2

// Memory depths in 32-bit words
`define USER_DOMAIN_ROM_WORDS 8
`define USER_DOMAIN_SRAM_WORDS 64

// Region bases, byte addresses
// ROM spans ROM_WORDS*4 = 32 bytes
`define USER_DOMAIN_ROM_BASE 32'h0000_0000
// SRAM spans SRAM_WORDS*4 = 256 bytes
`define USER_DOMAIN_SRAM_BASE 32'h0000_1000

// Bytes per bus word
`define USER_DOMAIN_BYTES_PER_WORD (`USER_DOMAIN_DATA_W / 8)

`endif
